// File: common/core_demux_consts.svh
// Bus widths, cluster page bases, page offsets and demux select bit
`ifndef CORE_DEMUX_CONSTS_SVH
`define CORE_DEMUX_CONSTS_SVH

// Core bus widths
`define CD_ADDR_W 32
`define CD_DATA_W 32
`define CD_BE_W   (`CD_DATA_W / 8)  // One enable per byte
`define CD_ATOP_W 6

// Cluster ID width, up to 64 clusters
`define CD_CID_W 6

// Page numbers are address bits 31:20
// Each cluster owns four pages starting at the page base
`define CD_PAGE_BASE  12'h100
`define CD_ALIAS_BASE 12'h000  // Cluster-local alias of the same pages

// Offsets of the three decoded pages within a cluster block
`define CD_OFS_TCDM_RW 12'd0
`define CD_OFS_TCDM_TS 12'd1  // Test-and-set view of TCDM
`define CD_OFS_DEM_PER 12'd2

// Within the demux peripheral page this bit picks EXT over PE
`define CD_DEM_SEL_BIT 14

`endif

// File: common/core_demux_pkg.sv
// Word types, destination encoding and address view union of the core demux
`include "core_demux_consts.svh"

package core_demux_pkg;

  // Core bus words
  typedef logic [`CD_ADDR_W-1:0] addr_t;
  typedef logic [`CD_DATA_W-1:0] data_t;
  typedef logic [`CD_BE_W-1:0]   be_t;
  typedef logic [`CD_ATOP_W-1:0] atop_t;

  // Page number, the top twelve address bits
  typedef logic [11:0] page_t;

  // Target port of a request
  typedef enum logic [1:0] {
    DEST_SH  = 2'd0,
    DEST_PE  = 2'd1,
    DEST_EXT = 2'd2
  } dest_e;

  // Address split at the page boundary
  typedef struct packed {
    page_t       page;
    logic [5:0]  mid;     // Bit 14 sits at the bottom of this field
    logic [13:0] offset;
  } page_view_t;

  // Address split at a page pair, TCDM RW and TS share one pair
  typedef struct packed {
    logic [10:0] pair;
    logic [20:0] rest;
  } pair_view_t;

  // One address word, decoded both ways
  typedef union packed {
    page_view_t page_v;
    pair_view_t pair_v;
  } addr_view_u;

endpackage

// File: verilog/addr_decoder.sv
// Page decoder with request steering, grant select and L2 perf events
`include "core_demux_consts.svh"

module addr_decoder #(
  parameter bit cluster_alias = 1'b1
) (
  input  logic                  data_req_i,
  input  core_demux_pkg::addr_t data_add_i,
  input  logic                  data_wen_i,
  input  logic [`CD_CID_W-1:0]  cluster_id_i,
  input  logic                  sh_gnt_i,
  input  logic                  ext_gnt_i,
  input  logic                  pe_gnt_i,
  output logic                  sh_req_o,
  output logic                  ext_req_o,
  output logic                  pe_sel_o,
  output logic                  data_gnt_o,
  output core_demux_pkg::dest_e dest_o,
  output logic                  perf_l2_ld_o,
  output logic                  perf_l2_st_o,
  output logic                  perf_l2_ld_cyc_o,
  output logic                  perf_l2_st_cyc_o
);
  import core_demux_pkg::*;

  addr_view_u addr_v;
  page_t      tcdm_rw, tcdm_ts, dem_per;
  page_t      alias_rw, alias_ts, alias_dem;
  logic       hit_pair;  // TCDM RW or TS, seen through the pair view
  logic       l2_req;
  logic       l2_gnt;

  assign addr_v = data_add_i;

  // Four pages per cluster above the page base
  assign tcdm_rw   = `CD_PAGE_BASE + page_t'({cluster_id_i, 2'b00}) + `CD_OFS_TCDM_RW;
  assign tcdm_ts   = `CD_PAGE_BASE + page_t'({cluster_id_i, 2'b00}) + `CD_OFS_TCDM_TS;
  assign dem_per   = `CD_PAGE_BASE + page_t'({cluster_id_i, 2'b00}) + `CD_OFS_DEM_PER;
  assign alias_rw  = `CD_ALIAS_BASE + `CD_OFS_TCDM_RW;
  assign alias_ts  = `CD_ALIAS_BASE + `CD_OFS_TCDM_TS;
  assign alias_dem = `CD_ALIAS_BASE + `CD_OFS_DEM_PER;

  always_comb begin
    hit_pair = (addr_v.pair_v.pair == tcdm_rw[11:1]) ||
               (cluster_alias && (addr_v.pair_v.pair == alias_rw[11:1]));

    // Destination from the full page number
    dest_o = DEST_PE;  // Default for the rest of the memory map
    if ((addr_v.page_v.page == tcdm_rw) || (addr_v.page_v.page == tcdm_ts) ||
        (cluster_alias && ((addr_v.page_v.page == alias_rw) ||
                           (addr_v.page_v.page == alias_ts)))) begin
      dest_o = DEST_SH;
    end else if ((addr_v.page_v.page == dem_per) ||
                 (cluster_alias && (addr_v.page_v.page == alias_dem))) begin
      dest_o = data_add_i[`CD_DEM_SEL_BIT] ? DEST_EXT : DEST_PE;
    end

    sh_req_o  = data_req_i & hit_pair;
    ext_req_o = data_req_i & (dest_o == DEST_EXT);
    pe_sel_o  = data_req_i & (dest_o == DEST_PE);

    // Pair view and page view have to agree on the TCDM pages
    assert ($onehot0({sh_req_o, ext_req_o, pe_sel_o}))
      else $error("addr_decoder: more than one target requested");
  end

  always_comb begin
    case (dest_o)
      DEST_SH:  data_gnt_o = sh_gnt_i;
      DEST_EXT: data_gnt_o = ext_gnt_i;
      default:  data_gnt_o = pe_gnt_i;
    endcase
  end

  // Everything leaving the cluster counts as L2
  assign l2_req = ext_req_o | pe_sel_o;
  assign l2_gnt = (dest_o == DEST_EXT) ? ext_gnt_i : pe_gnt_i;

  assign perf_l2_ld_cyc_o = l2_req & data_wen_i;
  assign perf_l2_st_cyc_o = l2_req & ~data_wen_i;
  assign perf_l2_ld_o     = l2_req & l2_gnt & data_wen_i;   // Granted loads
  assign perf_l2_st_o     = l2_req & l2_gnt & ~data_wen_i;

endmodule

// File: verilog/resp_tracker.sv
// Destination register and response multiplexer toward the core
module resp_tracker (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  data_req_i,
  input  core_demux_pkg::dest_e dest_i,
  input  logic                  sh_r_valid_i,
  input  core_demux_pkg::data_t sh_r_rdata_i,
  input  logic                  ext_r_valid_i,
  input  core_demux_pkg::data_t ext_r_rdata_i,
  input  logic                  ext_r_opc_i,
  input  logic                  pe_r_valid_i,
  input  core_demux_pkg::data_t pe_r_rdata_i,
  input  logic                  pe_r_opc_i,
  output logic                  data_r_valid_o,
  output core_demux_pkg::data_t data_r_rdata_o,
  output logic                  data_r_opc_o
);
  import core_demux_pkg::*;

  dest_e dest_q;  // Target of the last request

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      dest_q <= DEST_SH;
    end else if (data_req_i) begin
      dest_q <= dest_i;
    end
  end

  always_comb begin
    case (dest_q)
      DEST_SH: begin
        data_r_valid_o = sh_r_valid_i;
        data_r_rdata_o = sh_r_rdata_i;
        data_r_opc_o   = 1'b0;  // TCDM never reports an error
      end
      DEST_EXT: begin
        data_r_valid_o = ext_r_valid_i;
        data_r_rdata_o = ext_r_rdata_i;
        data_r_opc_o   = ext_r_opc_i;
      end
      DEST_PE: begin
        data_r_valid_o = pe_r_valid_i;
        data_r_rdata_o = pe_r_rdata_i;
        data_r_opc_o   = pe_r_opc_i;
      end
      default: begin
        data_r_valid_o = 1'b0;
        data_r_rdata_o = '0;
        data_r_opc_o   = 1'b0;
      end
    endcase
  end

  a_dest_legal: assert property (@(posedge clk) disable iff (!rst_ni)
    dest_q inside {DEST_SH, DEST_PE, DEST_EXT})
    else $error("resp_tracker: illegal destination encoding");

endmodule

// File: periph_bridge/periph_bridge.sv
// Peripheral transaction FSM and two-stage response retiming
module periph_bridge (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  pe_sel_i,
  input  logic                  pe_gnt_i,
  input  logic                  pe_r_valid_i,
  input  core_demux_pkg::data_t pe_r_rdata_i,
  input  logic                  pe_r_opc_i,
  output logic                  pe_req_o,
  output logic                  pe_gnt_o,
  output logic                  r_valid_o,
  output core_demux_pkg::data_t r_rdata_o,
  output logic                  r_opc_o
);
  import core_demux_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PENDING,  // Peripheral granted, waiting for its answer
    ST_GRANTED
  } state_e;

  state_e state_q, state_d;

  logic  valid_q0;
  data_t rdata_q0;
  logic  opc_q0;
  logic  valid_q1;
  data_t rdata_q1;
  logic  opc_q1;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d  = state_q;
    pe_req_o = 1'b0;
    pe_gnt_o = 1'b0;
    case (state_q)
      ST_IDLE: begin
        pe_req_o = pe_sel_i;  // Request goes out in the same cycle
        if (pe_sel_i && pe_gnt_i) begin
          state_d = ST_PENDING;
        end
      end
      ST_PENDING: begin
        if (pe_r_valid_i) begin
          state_d = ST_GRANTED;
        end
      end
      ST_GRANTED: begin
        // Core sees its grant only once the answer is in
        pe_gnt_o = 1'b1;
        state_d  = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Valid bit pipeline
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q0 <= 1'b0;
      valid_q1 <= 1'b0;
    end else begin
      valid_q0 <= pe_r_valid_i;
      valid_q1 <= valid_q0;
    end
  end

  // Response payload, captured only with its valid
  always_ff @(posedge clk) begin
    if (pe_r_valid_i) begin
      rdata_q0 <= pe_r_rdata_i;
      opc_q0   <= pe_r_opc_i;
    end
    if (valid_q0) begin
      rdata_q1 <= rdata_q0;
      opc_q1   <= opc_q0;
    end
  end

  assign r_valid_o = valid_q1;
  assign r_rdata_o = rdata_q1;
  assign r_opc_o   = opc_q1;

  // Peripheral answers only a request that it has granted
  a_rsp_when_pending: assert property (@(posedge clk) disable iff (!rst_ni)
    pe_r_valid_i |-> (state_q == ST_PENDING))
    else $error("periph_bridge: peripheral answer without a pending request");

  // Core keeps its request up until the bridge grants it
  a_sel_held: assert property (@(posedge clk) disable iff (!rst_ni)
    (state_q != ST_IDLE) |-> pe_sel_i)
    else $error("periph_bridge: core request dropped before its grant");

endmodule

// File: verilog/core_demux_top.sv
// Core demux top level with address decoder, response tracker and peripheral bridge
`include "core_demux_consts.svh"

module core_demux_top #(
  parameter bit cluster_alias = 1'b1
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic [`CD_CID_W-1:0]  cluster_id_i,

  // Core request and response
  input  logic                  data_req_i,
  input  core_demux_pkg::addr_t data_add_i,
  input  logic                  data_wen_i,    // 1 = load
  input  core_demux_pkg::atop_t data_atop_i,
  input  core_demux_pkg::data_t data_wdata_i,
  input  core_demux_pkg::be_t   data_be_i,
  output logic                  data_gnt_o,
  output logic                  data_r_valid_o,
  output core_demux_pkg::data_t data_r_rdata_o,
  output logic                  data_r_opc_o,

  // Shared memory port (TCDM)
  output logic                  sh_req_o,
  output core_demux_pkg::addr_t sh_add_o,
  output logic                  sh_wen_o,
  output core_demux_pkg::atop_t sh_atop_o,
  output core_demux_pkg::data_t sh_wdata_o,
  output core_demux_pkg::be_t   sh_be_o,
  input  logic                  sh_gnt_i,
  input  logic                  sh_r_valid_i,
  input  core_demux_pkg::data_t sh_r_rdata_i,

  // Demux peripherals outside the cluster
  output logic                  ext_req_o,
  output core_demux_pkg::addr_t ext_add_o,
  output logic                  ext_wen_o,
  output core_demux_pkg::data_t ext_wdata_o,
  output core_demux_pkg::be_t   ext_be_o,
  input  logic                  ext_gnt_i,
  input  logic                  ext_r_valid_i,
  input  core_demux_pkg::data_t ext_r_rdata_i,
  input  logic                  ext_r_opc_i,

  // Peripheral interconnect, behind the bridge
  output logic                  pe_req_o,
  output core_demux_pkg::addr_t pe_add_o,
  output logic                  pe_wen_o,
  output core_demux_pkg::atop_t pe_atop_o,
  output core_demux_pkg::data_t pe_wdata_o,
  output core_demux_pkg::be_t   pe_be_o,
  input  logic                  pe_gnt_i,
  input  logic                  pe_r_valid_i,
  input  core_demux_pkg::data_t pe_r_rdata_i,
  input  logic                  pe_r_opc_i,

  // L2 performance events
  output logic                  perf_l2_ld_o,
  output logic                  perf_l2_st_o,
  output logic                  perf_l2_ld_cyc_o,
  output logic                  perf_l2_st_cyc_o
);
  import core_demux_pkg::*;

  dest_e dest;
  logic  pe_sel;
  logic  pe_core_gnt;   // Core grant from the bridge
  logic  pe_rsp_valid;  // Retimed PE response
  data_t pe_rsp_rdata;
  logic  pe_rsp_opc;

  // Payload fans out to every target, only the request strobe is steered
  assign sh_add_o    = data_add_i;
  assign sh_wen_o    = data_wen_i;
  assign sh_atop_o   = data_atop_i;
  assign sh_wdata_o  = data_wdata_i;
  assign sh_be_o     = data_be_i;

  assign ext_add_o   = data_add_i;
  assign ext_wen_o   = data_wen_i;
  assign ext_wdata_o = data_wdata_i;
  assign ext_be_o    = data_be_i;

  assign pe_add_o    = data_add_i;
  assign pe_wen_o    = data_wen_i;
  assign pe_atop_o   = data_atop_i;
  assign pe_wdata_o  = data_wdata_i;
  assign pe_be_o     = data_be_i;

  addr_decoder #(
    .cluster_alias (cluster_alias)
  ) u_addr_decoder (
    .data_req_i       (data_req_i),
    .data_add_i       (data_add_i),
    .data_wen_i       (data_wen_i),
    .cluster_id_i     (cluster_id_i),
    .sh_gnt_i         (sh_gnt_i),
    .ext_gnt_i        (ext_gnt_i),
    .pe_gnt_i         (pe_core_gnt),
    .sh_req_o         (sh_req_o),
    .ext_req_o        (ext_req_o),
    .pe_sel_o         (pe_sel),
    .data_gnt_o       (data_gnt_o),
    .dest_o           (dest),
    .perf_l2_ld_o     (perf_l2_ld_o),
    .perf_l2_st_o     (perf_l2_st_o),
    .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o),
    .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
  );

  resp_tracker u_resp_tracker (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .data_req_i     (data_req_i),
    .dest_i         (dest),
    .sh_r_valid_i   (sh_r_valid_i),
    .sh_r_rdata_i   (sh_r_rdata_i),
    .ext_r_valid_i  (ext_r_valid_i),
    .ext_r_rdata_i  (ext_r_rdata_i),
    .ext_r_opc_i    (ext_r_opc_i),
    .pe_r_valid_i   (pe_rsp_valid),
    .pe_r_rdata_i   (pe_rsp_rdata),
    .pe_r_opc_i     (pe_rsp_opc),
    .data_r_valid_o (data_r_valid_o),
    .data_r_rdata_o (data_r_rdata_o),
    .data_r_opc_o   (data_r_opc_o)
  );

  periph_bridge u_periph_bridge (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .pe_sel_i     (pe_sel),
    .pe_gnt_i     (pe_gnt_i),
    .pe_r_valid_i (pe_r_valid_i),
    .pe_r_rdata_i (pe_r_rdata_i),
    .pe_r_opc_i   (pe_r_opc_i),
    .pe_req_o     (pe_req_o),
    .pe_gnt_o     (pe_core_gnt),
    .r_valid_o    (pe_rsp_valid),
    .r_rdata_o    (pe_rsp_rdata),
    .r_opc_o      (pe_rsp_opc)
  );

endmodule

// File: verif/tb_core_demux.sv
// Testbench for core_demux_top with LFSR stimulus, target models and a reference model
`include "core_demux_consts.svh"

module tb_core_demux;
  import core_demux_pkg::*;

  localparam int N_TXN   = 300;
  localparam int MAX_CYC = N_TXN * 20 + 100;
  localparam bit ALIAS   = 1'b1;  // DUT keeps its default

  logic                 clk = 1'b0;
  logic                 rst_ni;
  logic [`CD_CID_W-1:0] cluster_id_i;
  logic  data_req_i, data_wen_i, data_gnt_o, data_r_valid_o, data_r_opc_o;
  addr_t data_add_i;
  atop_t data_atop_i;
  data_t data_wdata_i, data_r_rdata_o;
  be_t   data_be_i;
  logic  sh_req_o, sh_wen_o, sh_gnt_i, sh_r_valid_i;
  addr_t sh_add_o;
  atop_t sh_atop_o;
  data_t sh_wdata_o, sh_r_rdata_i;
  be_t   sh_be_o;
  logic  ext_req_o, ext_wen_o, ext_gnt_i, ext_r_valid_i, ext_r_opc_i;
  addr_t ext_add_o;
  data_t ext_wdata_o, ext_r_rdata_i;
  be_t   ext_be_o;
  logic  pe_req_o, pe_wen_o, pe_gnt_i, pe_r_valid_i, pe_r_opc_i;
  addr_t pe_add_o;
  atop_t pe_atop_o;
  data_t pe_wdata_o, pe_r_rdata_i;
  be_t   pe_be_o;
  logic  perf_l2_ld_o, perf_l2_st_o, perf_l2_ld_cyc_o, perf_l2_st_cyc_o;

  logic [31:0] lfsr = 32'h4b8a67fc;
  int cycle_cnt = 0;
  int err_bit   = 0;
  int err_data  = 0;
  int err_dest  = 0;

  core_demux_top dut (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYC) begin
      $display("Timeout: test did not finish within %0d cycles", MAX_CYC);
      report_counts();
      $display(">>> FAIL");
      $finish;
    end
  end

  // Galois LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // Expected target from the page map of this cluster
  function automatic dest_e model_dest(input addr_t a);
    page_t pg;
    page_t base;
    pg   = a[31:20];
    base = `CD_PAGE_BASE + page_t'({cluster_id_i, 2'b00});
    if (pg == base + `CD_OFS_TCDM_RW || pg == base + `CD_OFS_TCDM_TS ||
        (ALIAS && (pg == `CD_ALIAS_BASE + `CD_OFS_TCDM_RW ||
                   pg == `CD_ALIAS_BASE + `CD_OFS_TCDM_TS)))
      return DEST_SH;
    if (pg == base + `CD_OFS_DEM_PER || (ALIAS && pg == `CD_ALIAS_BASE + `CD_OFS_DEM_PER))
      return a[`CD_DEM_SEL_BIT] ? DEST_EXT : DEST_PE;
    return DEST_PE;  // Anything else leaves through the peripheral bus
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_bit++;
      $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      err_data++;
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      err_data++;
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_dest(input string name, input dest_e got, input dest_e exp);
    if (got !== exp) begin
      err_dest++;
      $display("ERR t=%0t %s got=%s exp=%s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_payload(input string port, input addr_t add, input logic wen,
                               input data_t wdata, input be_t be);
    check_addr({port, "_add_o"}, add, data_add_i);
    check_bit({port, "_wen_o"}, wen, data_wen_i);
    check_data({port, "_wdata_o"}, wdata, data_wdata_i);
    check_data({port, "_be_o"}, data_t'(be), data_t'(data_be_i));
  endtask

  task automatic clear_inputs();
    {data_req_i, data_wen_i, sh_gnt_i, sh_r_valid_i, ext_gnt_i, ext_r_valid_i} = '0;
    {ext_r_opc_i, pe_gnt_i, pe_r_valid_i, pe_r_opc_i} = '0;
    data_add_i    = '0;
    data_atop_i   = '0;
    data_wdata_i  = '0;
    data_be_i     = '0;
    sh_r_rdata_i  = '0;
    ext_r_rdata_i = '0;
    pe_r_rdata_i  = '0;
  endtask

  task automatic report_counts();
    $display("Errors: dest %0d, data %0d, bit %0d", err_dest, err_data, err_bit);
  endtask

  // One core transaction, targets answer on a random schedule
  task automatic run_txn();
    int    sel, gnt_dly, v_cyc, gnt_cyc, rv_cyc, cyc;
    page_t pg;
    addr_t add;
    dest_e exp_dest;
    data_t rsp_data;
    logic  rsp_opc, req_on, done, l2;
    sel = int'(take_bits(3));
    case (sel)
      0, 1, 2: pg = `CD_PAGE_BASE + page_t'({cluster_id_i, 2'b00}) + page_t'(sel);
      3, 4, 5: pg = `CD_ALIAS_BASE + page_t'(sel - 3);
      default: pg = page_t'(take_bits(12));  // Mostly off the cluster map
    endcase
    add = {pg, 20'(take_bits(20))};
    add[`CD_DEM_SEL_BIT] = 1'(take_bits(1));
    exp_dest = model_dest(add);
    gnt_dly  = int'(take_bits(2));
    v_cyc    = gnt_dly + 1 + int'(take_bits(2));
    gnt_cyc  = (exp_dest == DEST_PE) ? v_cyc + 1 : gnt_dly;  // Bridge grants after the answer
    rv_cyc   = (exp_dest == DEST_PE) ? v_cyc + 2 : v_cyc;
    rsp_data = data_t'(take_bits(32));
    rsp_opc  = 1'(take_bits(1));
    @(negedge clk);
    data_add_i   = add;
    data_wen_i   = 1'(take_bits(1));
    data_atop_i  = atop_t'(take_bits(`CD_ATOP_W));
    data_wdata_i = data_t'(take_bits(32));
    data_be_i    = be_t'(take_bits(`CD_BE_W));
    req_on = 1'b1;
    done   = 1'b0;
    cyc    = 0;
    while (!done) begin
      if (cyc > 0) @(negedge clk);
      data_req_i    = req_on;
      sh_gnt_i      = (exp_dest == DEST_SH) && (cyc == gnt_dly);
      ext_gnt_i     = (exp_dest == DEST_EXT) && (cyc == gnt_dly);
      pe_gnt_i      = (exp_dest == DEST_PE) && (cyc == gnt_dly);
      sh_r_valid_i  = (exp_dest == DEST_SH) && (cyc == v_cyc);
      ext_r_valid_i = (exp_dest == DEST_EXT) && (cyc == v_cyc);
      pe_r_valid_i  = (exp_dest == DEST_PE) && (cyc == v_cyc);
      sh_r_rdata_i  = sh_r_valid_i ? rsp_data : '0;
      ext_r_rdata_i = ext_r_valid_i ? rsp_data : '0;
      ext_r_opc_i   = ext_r_valid_i & rsp_opc;
      pe_r_rdata_i  = pe_r_valid_i ? rsp_data : '0;  // PE data must come from the latches
      pe_r_opc_i    = pe_r_valid_i & rsp_opc;
      @(posedge clk);
      l2 = req_on && (exp_dest != DEST_SH);
      check_bit("sh_req_o", sh_req_o, req_on && (exp_dest == DEST_SH));
      check_bit("ext_req_o", ext_req_o, req_on && (exp_dest == DEST_EXT));
      check_bit("pe_req_o", pe_req_o, req_on && (exp_dest == DEST_PE) && (cyc <= gnt_dly));
      check_bit("data_gnt_o", data_gnt_o, cyc == gnt_cyc);
      check_bit("data_r_valid_o", data_r_valid_o, cyc == rv_cyc);
      check_bit("perf_l2_ld_cyc_o", perf_l2_ld_cyc_o, l2 && data_wen_i);
      check_bit("perf_l2_st_cyc_o", perf_l2_st_cyc_o, l2 && !data_wen_i);
      check_bit("perf_l2_ld_o", perf_l2_ld_o, l2 && data_wen_i && (cyc == gnt_cyc));
      check_bit("perf_l2_st_o", perf_l2_st_o, l2 && !data_wen_i && (cyc == gnt_cyc));
      if (req_on) begin
        check_dest("dut.dest", dut.dest, exp_dest);
        case (exp_dest)
          DEST_SH: begin
            check_payload("sh", sh_add_o, sh_wen_o, sh_wdata_o, sh_be_o);
            check_data("sh_atop_o", data_t'(sh_atop_o), data_t'(data_atop_i));
          end
          DEST_EXT: check_payload("ext", ext_add_o, ext_wen_o, ext_wdata_o, ext_be_o);
          default: begin
            check_payload("pe", pe_add_o, pe_wen_o, pe_wdata_o, pe_be_o);
            check_data("pe_atop_o", data_t'(pe_atop_o), data_t'(data_atop_i));
          end
        endcase
      end
      if (data_r_valid_o) begin
        check_data("data_r_rdata_o", data_r_rdata_o, rsp_data);
        check_bit("data_r_opc_o", data_r_opc_o, (exp_dest == DEST_SH) ? 1'b0 : rsp_opc);
        done = 1'b1;
      end
      if (data_gnt_o) req_on = 1'b0;  // Core drops its request once granted
      cyc++;
    end
  endtask

  initial begin
    cluster_id_i = (`CD_CID_W)'(take_bits(`CD_CID_W));
    rst_ni = 1'b0;
    clear_inputs();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_ni = 1'b1;
    @(posedge clk);
    check_bit("data_r_valid_o", data_r_valid_o, 1'b0);  // Quiet after reset
    check_bit("pe_req_o", pe_req_o, 1'b0);
    check_bit("sh_req_o", sh_req_o, 1'b0);
    check_bit("ext_req_o", ext_req_o, 1'b0);
    for (int i = 0; i < N_TXN; i++) begin
      run_txn();
    end
    @(negedge clk);
    clear_inputs();
    @(posedge clk);
    report_counts();
    if (err_bit + err_data + err_dest == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+common
common/core_demux_pkg.sv
verilog/addr_decoder.sv
verilog/resp_tracker.sv
periph_bridge/periph_bridge.sv
verilog/core_demux_top.sv
verif/tb_core_demux.sv

// File: Makefile
# Verilator build and run of the core demux testbench

VERILATOR ?= verilator
TOP       ?= tb_core_demux
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
